// File: src/fu_macros.svh
/*
 * Sizing and latencies of the execution lanes.
 * A latency counts rising edges from the accepting edge up to and including
 * the edge that raises res_valid. The minimum is 1.
 */
`ifndef FU_MACROS_SVH
`define FU_MACROS_SVH

////////////////////
// datapath
////////////////////

// operand and result width for RV32
`define FU_XLEN      32
// physical register tag
`define FU_TAG_W     6

////////////////////
// lane latency
////////////////////

`define FU_ALU_LAT   1
// combinational multiplier modelled as a multicycle path
`define FU_MULT_LAT  4
`define FU_BR_LAT    1

`endif

// File: src/isa_pkg.sv
/*
 * RISC-V encodings seen by the execution lanes.
 * br_cond_e matches funct3 of the B-type format.
 */
package isa_pkg;

    ////////////////////
    // function codes
    ////////////////////

    // shared by the ALU, the multiplier and the branch target adder
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_MUL    = 4'd10,
        ALU_MULH   = 4'd11,
        ALU_MULHSU = 4'd12,
        ALU_MULHU  = 4'd13
    } alu_func_e;

    ////////////////////
    // operand sources
    ////////////////////

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    // codes 6 and 7 are not used
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    ////////////////////
    // branches
    ////////////////////

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

    // jal and jalr are UNCOND
    typedef enum logic {
        BR_COND   = 1'b0,
        BR_UNCOND = 1'b1
    } br_kind_e;

endpackage

// File: src/fu_pkg.sv
/*
 * Pipeline-side types shared by the issue side and the lanes.
 * issue_t is latched whole when a lane accepts an instruction.
 * Compile after isa_pkg.
 */
`include "fu_macros.svh"

package fu_pkg;

    // physical destination register
    typedef logic [`FU_TAG_W-1:0] tag_t;

    // one issued instruction as a lane holds it
    typedef struct packed {
        isa_pkg::alu_func_e  func;
        isa_pkg::opa_sel_e   opa_sel;
        isa_pkg::opb_sel_e   opb_sel;
        isa_pkg::br_kind_e   br_kind;
        // register operands read at issue
        logic [`FU_XLEN-1:0] rs1;
        logic [`FU_XLEN-1:0] rs2;
        logic [`FU_XLEN-1:0] pc;
        // raw word, source of immediates and funct3
        logic [`FU_XLEN-1:0] inst;
        tag_t                tag;
    } issue_t;

endpackage

// File: src/operand_select.sv
/*
 * Operand A/B selection for one lane. Purely combinational.
 * Immediates follow the RV32 base formats, so FU_XLEN must be 32.
 * Codes 6 and 7 of opb_sel are flagged in simulation.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module operand_select (
    input  fu_pkg::issue_t      inst_q_i,
    output logic [`FU_XLEN-1:0] opa_o,
    output logic [`FU_XLEN-1:0] opb_o
);
    import isa_pkg::*;

    logic [`FU_XLEN-1:0] inst;
    logic [`FU_XLEN-1:0] npc;
    logic [`FU_XLEN-1:0] imm_i;
    logic [`FU_XLEN-1:0] imm_s;
    logic [`FU_XLEN-1:0] imm_b;
    logic [`FU_XLEN-1:0] imm_u;
    logic [`FU_XLEN-1:0] imm_j;

    assign inst = inst_q_i.inst;
    // link address
    assign npc  = inst_q_i.pc + `FU_XLEN'd4;

    ////////////////////
    // immediates
    ////////////////////

    // sign always comes from inst[31]
    assign imm_i = {{(`FU_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`FU_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    // B and J drop bit 0
    assign imm_b = {{(`FU_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], {12{1'b0}}};
    assign imm_j = {{(`FU_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    ////////////////////
    // muxes
    ////////////////////

    always_comb begin
        case (inst_q_i.opa_sel)
            OPA_IS_RS1: opa_o = inst_q_i.rs1;
            OPA_IS_NPC: opa_o = npc;
            OPA_IS_PC:  opa_o = inst_q_i.pc;
            default:    opa_o = '0;
        endcase
    end

    always_comb begin
        case (inst_q_i.opb_sel)
            OPB_IS_RS2:   opb_o = inst_q_i.rs2;
            OPB_IS_I_IMM: opb_o = imm_i;
            OPB_IS_S_IMM: opb_o = imm_s;
            OPB_IS_B_IMM: opb_o = imm_b;
            OPB_IS_U_IMM: opb_o = imm_u;
            OPB_IS_J_IMM: opb_o = imm_j;
            // unused codes
            default:      opb_o = '0;
        endcase
    end

    // a loaded record must carry a B select inside the enum range
    always_comb begin
        if (!$isunknown(inst_q_i.opb_sel)) begin
            assert (inst_q_i.opb_sel inside {OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
                                             OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM})
                else $error("operand_select: opb_sel %0d out of range", inst_q_i.opb_sel);
        end
    end

endmodule

// File: src/fu_issue_ctrl.sv
/*
 * Handshake and valid pipeline of one lane. LATENCY must be 1 or more.
 * Only one instruction is in flight. ready_o also rises in the cycle the
 * result is acknowledged, so issue can go back to back.
 * flush_i squashes the pipeline and hides a result at the head at once.
 */
`timescale 1ns/1ps

module fu_issue_ctrl #(
    parameter int LATENCY = 1
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           flush_i,
    input  logic           valid_i,
    output logic           ready_o,
    input  fu_pkg::issue_t inst_i,
    output fu_pkg::issue_t inst_q_o,
    output logic           res_valid_o,
    input  logic           ack_i
);
    logic [LATENCY-1:0] valid_sh;
    logic [LATENCY-1:0] valid_nxt;
    logic               accept;
    logic               consume;
    logic               stall;

    assign accept  = valid_i && ready_o;
    assign consume = res_valid_o && ack_i;
    // result waiting on the broadcaster
    assign stall   = res_valid_o && !ack_i;

    // MSB is the result slot
    assign res_valid_o = valid_sh[LATENCY-1] && !flush_i;
    // empty lane or the head leaves this cycle
    assign ready_o = (valid_sh == '0) || consume;

    // instruction record, loaded on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q_o <= inst_i;
        end
    end

    ////////////////////
    // valid pipeline
    ////////////////////

    if (LATENCY == 1) begin : g_single
        assign valid_nxt = accept;
    end else begin : g_shift
        // old head falls off the top
        assign valid_nxt = {valid_sh[LATENCY-2:0], accept};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_sh <= '0;
        end else if (!stall) begin
            valid_sh <= valid_nxt;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // held result keeps both valid and payload until acked
    a_hold_until_ack : assert property (@(posedge clk_i) disable iff (rst_i)
        res_valid_o && !ack_i |=> flush_i || (res_valid_o && $stable(inst_q_o)))
        else $error("fu_issue_ctrl: result dropped or changed before ack");

    // no second issue while the accepted one is still in the lane
    a_busy_not_ready : assert property (@(posedge clk_i) disable iff (rst_i)
        accept && !flush_i |=> !ready_o || consume)
        else $error("fu_issue_ctrl: ready while busy");

endmodule

// File: src/alu_core.sv
/*
 * Combinational integer ALU.
 * Shifts use the low log2(FU_XLEN) bits of B.
 * Multiply codes and unknown codes give zero.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module alu_core (
    input  logic [`FU_XLEN-1:0] opa_i,
    input  logic [`FU_XLEN-1:0] opb_i,
    input  isa_pkg::alu_func_e  func_i,
    output logic [`FU_XLEN-1:0] result_o
);
    import isa_pkg::*;

    localparam int SHAMT_W = $clog2(`FU_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = opb_i[SHAMT_W-1:0];
    assign lt_s  = $signed(opa_i) < $signed(opb_i);
    assign lt_u  = opa_i < opb_i;

    always_comb begin
        case (func_i)
            ALU_ADD:  result_o = opa_i + opb_i;
            ALU_SUB:  result_o = opa_i - opb_i;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;
            // compare result in bit 0
            ALU_SLT:  result_o = {{(`FU_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`FU_XLEN-1){1'b0}}, lt_u};
            ALU_SLL:  result_o = opa_i << shamt;
            ALU_SRL:  result_o = opa_i >> shamt;
            ALU_SRA:  result_o = $signed(opa_i) >>> shamt;
            default:  result_o = '0;
        endcase
    end

endmodule

// File: src/mult_core.sv
/*
 * Combinational 32x32 multiplier. The lane timing treats it as a
 * multicycle path. Non-multiply codes give zero.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module mult_core (
    input  logic [`FU_XLEN-1:0] opa_i,
    input  logic [`FU_XLEN-1:0] opb_i,
    input  isa_pkg::alu_func_e  func_i,
    output logic [`FU_XLEN-1:0] result_o
);
    import isa_pkg::*;

    logic [2*`FU_XLEN-1:0] opa_sx;
    logic [2*`FU_XLEN-1:0] opb_sx;
    logic [2*`FU_XLEN-1:0] opb_zx;
    logic [2*`FU_XLEN-1:0] prod_ss;
    logic [2*`FU_XLEN-1:0] prod_su;
    logic [2*`FU_XLEN-1:0] prod_uu;

    // extend first so a plain product is exact in double width
    assign opa_sx = {{`FU_XLEN{opa_i[`FU_XLEN-1]}}, opa_i};
    assign opb_sx = {{`FU_XLEN{opb_i[`FU_XLEN-1]}}, opb_i};
    assign opb_zx = {{`FU_XLEN{1'b0}}, opb_i};

    assign prod_ss = opa_sx * opb_sx;
    assign prod_su = opa_sx * opb_zx;
    assign prod_uu = {{`FU_XLEN{1'b0}}, opa_i} * opb_zx;

    always_comb begin
        case (func_i)
            // low word is the same for every signedness
            ALU_MUL:    result_o = prod_ss[`FU_XLEN-1:0];
            ALU_MULH:   result_o = prod_ss[2*`FU_XLEN-1:`FU_XLEN];
            ALU_MULHSU: result_o = prod_su[2*`FU_XLEN-1:`FU_XLEN];
            ALU_MULHU:  result_o = prod_uu[2*`FU_XLEN-1:`FU_XLEN];
            default:    result_o = '0;
        endcase
    end

endmodule

// File: src/branch_resolve.sv
/*
 * Branch decision from the latched record. Purely combinational.
 * The condition comes from funct3 in inst[14:12].
 * link_value_o is pc+4 for UNCOND and zero otherwise.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module branch_resolve (
    input  fu_pkg::issue_t      inst_q_i,
    output logic                taken_o,
    output logic                link_o,
    output logic [`FU_XLEN-1:0] link_value_o
);
    import isa_pkg::*;

    br_cond_e cond;
    logic     cond_hit;
    logic     uncond;

    assign cond   = br_cond_e'(inst_q_i.inst[14:12]);
    assign uncond = (inst_q_i.br_kind == BR_UNCOND);

    // rs1 against rs2
    always_comb begin
        case (cond)
            BR_BEQ:  cond_hit = (inst_q_i.rs1 == inst_q_i.rs2);
            BR_BNE:  cond_hit = (inst_q_i.rs1 != inst_q_i.rs2);
            BR_BLT:  cond_hit = ($signed(inst_q_i.rs1) < $signed(inst_q_i.rs2));
            BR_BGE:  cond_hit = ($signed(inst_q_i.rs1) >= $signed(inst_q_i.rs2));
            BR_BLTU: cond_hit = (inst_q_i.rs1 < inst_q_i.rs2);
            BR_BGEU: cond_hit = (inst_q_i.rs1 >= inst_q_i.rs2);
            // funct3 2 and 3 are no branch
            default: cond_hit = 1'b0;
        endcase
    end

    // jumps are always taken
    assign taken_o      = uncond || cond_hit;
    assign link_o       = uncond;
    assign link_value_o = uncond ? (inst_q_i.pc + `FU_XLEN'd4) : '0;

    // a conditional branch carries one of the six B-type funct3 codes
    always_comb begin
        if (inst_q_i.br_kind == BR_COND) begin
            assert (cond inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU})
                else $error("branch_resolve: funct3 %0d is no branch", inst_q_i.inst[14:12]);
        end
    end

endmodule

// File: src/fu_top.sv
/*
 * Execution stage with one ALU, one multiplier and one branch lane.
 * Each lane follows the valid/ready issue and res_valid/ack result protocol.
 * flush_i empties all three lanes on the next edge.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module fu_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                flush_i,
    // ALU lane
    input  logic                alu_valid_i,
    output logic                alu_ready_o,
    input  isa_pkg::alu_func_e  alu_func_i,
    input  isa_pkg::opa_sel_e   alu_opa_sel_i,
    input  isa_pkg::opb_sel_e   alu_opb_sel_i,
    input  logic [`FU_XLEN-1:0] alu_rs1_i,
    input  logic [`FU_XLEN-1:0] alu_rs2_i,
    input  logic [`FU_XLEN-1:0] alu_pc_i,
    input  logic [`FU_XLEN-1:0] alu_inst_i,
    input  fu_pkg::tag_t        alu_tag_i,
    output logic                alu_res_valid_o,
    output logic [`FU_XLEN-1:0] alu_res_o,
    output fu_pkg::tag_t        alu_res_tag_o,
    input  logic                alu_ack_i,
    // multiplier lane
    input  logic                mul_valid_i,
    output logic                mul_ready_o,
    input  isa_pkg::alu_func_e  mul_func_i,
    input  isa_pkg::opa_sel_e   mul_opa_sel_i,
    input  isa_pkg::opb_sel_e   mul_opb_sel_i,
    input  logic [`FU_XLEN-1:0] mul_rs1_i,
    input  logic [`FU_XLEN-1:0] mul_rs2_i,
    input  logic [`FU_XLEN-1:0] mul_pc_i,
    input  logic [`FU_XLEN-1:0] mul_inst_i,
    input  fu_pkg::tag_t        mul_tag_i,
    output logic                mul_res_valid_o,
    output logic [`FU_XLEN-1:0] mul_res_o,
    output fu_pkg::tag_t        mul_res_tag_o,
    input  logic                mul_ack_i,
    // branch lane
    input  logic                br_valid_i,
    output logic                br_ready_o,
    input  isa_pkg::alu_func_e  br_func_i,
    input  isa_pkg::opa_sel_e   br_opa_sel_i,
    input  isa_pkg::opb_sel_e   br_opb_sel_i,
    input  logic [`FU_XLEN-1:0] br_rs1_i,
    input  logic [`FU_XLEN-1:0] br_rs2_i,
    input  logic [`FU_XLEN-1:0] br_pc_i,
    input  logic [`FU_XLEN-1:0] br_inst_i,
    input  fu_pkg::tag_t        br_tag_i,
    input  isa_pkg::br_kind_e   br_kind_i,
    output logic                br_res_valid_o,
    output logic [`FU_XLEN-1:0] br_res_o,
    output fu_pkg::tag_t        br_res_tag_o,
    input  logic                br_ack_i,
    output logic                br_taken_o,
    output logic [`FU_XLEN-1:0] br_target_o,
    output logic                br_link_o
);
    import isa_pkg::*;
    import fu_pkg::*;

    issue_t              alu_inst;
    issue_t              alu_inst_q;
    logic [`FU_XLEN-1:0] alu_opa;
    logic [`FU_XLEN-1:0] alu_opb;
    issue_t              mul_inst;
    issue_t              mul_inst_q;
    logic [`FU_XLEN-1:0] mul_opa;
    logic [`FU_XLEN-1:0] mul_opb;
    issue_t              br_inst;
    issue_t              br_inst_q;
    logic [`FU_XLEN-1:0] br_opa;
    logic [`FU_XLEN-1:0] br_opb;

    ////////////////////
    // ALU lane
    ////////////////////

    // non-branch lanes carry kind COND
    assign alu_inst = '{alu_func_i, alu_opa_sel_i, alu_opb_sel_i, BR_COND,
                        alu_rs1_i, alu_rs2_i, alu_pc_i, alu_inst_i, alu_tag_i};

    fu_issue_ctrl #(.LATENCY(`FU_ALU_LAT)) i_alu_ctrl (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (flush_i),
        .valid_i (alu_valid_i), .ready_o (alu_ready_o),
        .inst_i (alu_inst), .inst_q_o (alu_inst_q),
        .res_valid_o (alu_res_valid_o), .ack_i (alu_ack_i)
    );
    operand_select i_alu_opsel (.inst_q_i (alu_inst_q), .opa_o (alu_opa), .opb_o (alu_opb));
    alu_core i_alu_core (
        .opa_i (alu_opa), .opb_i (alu_opb), .func_i (alu_inst_q.func), .result_o (alu_res_o)
    );
    assign alu_res_tag_o = alu_inst_q.tag;

    ////////////////////
    // multiplier lane
    ////////////////////

    assign mul_inst = '{mul_func_i, mul_opa_sel_i, mul_opb_sel_i, BR_COND,
                        mul_rs1_i, mul_rs2_i, mul_pc_i, mul_inst_i, mul_tag_i};

    fu_issue_ctrl #(.LATENCY(`FU_MULT_LAT)) i_mul_ctrl (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (flush_i),
        .valid_i (mul_valid_i), .ready_o (mul_ready_o),
        .inst_i (mul_inst), .inst_q_o (mul_inst_q),
        .res_valid_o (mul_res_valid_o), .ack_i (mul_ack_i)
    );
    operand_select i_mul_opsel (.inst_q_i (mul_inst_q), .opa_o (mul_opa), .opb_o (mul_opb));
    mult_core i_mul_core (
        .opa_i (mul_opa), .opb_i (mul_opb), .func_i (mul_inst_q.func), .result_o (mul_res_o)
    );
    assign mul_res_tag_o = mul_inst_q.tag;

    ////////////////////
    // branch lane
    ////////////////////

    assign br_inst = '{br_func_i, br_opa_sel_i, br_opb_sel_i, br_kind_i,
                       br_rs1_i, br_rs2_i, br_pc_i, br_inst_i, br_tag_i};

    fu_issue_ctrl #(.LATENCY(`FU_BR_LAT)) i_br_ctrl (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (flush_i),
        .valid_i (br_valid_i), .ready_o (br_ready_o),
        .inst_i (br_inst), .inst_q_o (br_inst_q),
        .res_valid_o (br_res_valid_o), .ack_i (br_ack_i)
    );
    operand_select i_br_opsel (.inst_q_i (br_inst_q), .opa_o (br_opa), .opb_o (br_opb));
    // target from the issued function, normally ADD
    alu_core i_br_target (
        .opa_i (br_opa), .opb_i (br_opb), .func_i (br_inst_q.func), .result_o (br_target_o)
    );
    // result word is the link value
    branch_resolve i_br_resolve (
        .inst_q_i (br_inst_q), .taken_o (br_taken_o),
        .link_o (br_link_o), .link_value_o (br_res_o)
    );
    assign br_res_tag_o = br_inst_q.tag;

endmodule

// File: test/fu_vectors.svh
/*
 * Directed vectors for the execution stage, one helper call per entry.
 * Expected values are worked out by hand from the RV32 rules.
 * Branches issue at pc 0x400 and form their target with ADD.
 */
`ifndef FU_VECTORS_SVH
`define FU_VECTORS_SVH

task automatic load_table();
    // alu: func, opa, opb, rs1, rs2, pc, inst, ack delay, result
    add_alu(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, 'h5, 'h7, 'h0, 'h0, 0, 'hc);
    add_alu(ALU_SUB, OPA_IS_RS1, OPB_IS_RS2, 'h5, 'h7, 'h0, 'h0, 0, 'hffff_fffe);
    add_alu(ALU_AND, OPA_IS_RS1, OPB_IS_RS2, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 'h0, 0, 'hf000_f000);
    add_alu(ALU_OR, OPA_IS_RS1, OPB_IS_RS2, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 'h0, 0, 'hfff0_fff0);
    add_alu(ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, 'hf0f0_f0f0, 'hff00_ff00, 'h0, 'h0, 0, 'h0ff0_0ff0);
    add_alu(ALU_SLT, OPA_IS_RS1, OPB_IS_RS2, 'hffff_ffff, 'h1, 'h0, 'h0, 0, 'h1);
    add_alu(ALU_SLTU, OPA_IS_RS1, OPB_IS_RS2, 'hffff_ffff, 'h1, 'h0, 'h0, 0, 'h0);
    // shift amount uses only the low 5 bits
    add_alu(ALU_SLL, OPA_IS_RS1, OPB_IS_RS2, 'h1, 'h24, 'h0, 'h0, 0, 'h10);
    add_alu(ALU_SRL, OPA_IS_RS1, OPB_IS_RS2, 'h8000_0000, 'h4, 'h0, 'h0, 0, 'h0800_0000);
    add_alu(ALU_SRA, OPA_IS_RS1, OPB_IS_RS2, 'h8000_0000, 'h4, 'h0, 'h0, 0, 'hf800_0000);
    // addi -4 on pc, lui, sw offset -8, pc+4
    add_alu(ALU_ADD, OPA_IS_PC, OPB_IS_I_IMM, 'h0, 'h0, 'h1000, 'hffc0_0013, 0, 'hffc);
    add_alu(ALU_ADD, OPA_IS_ZERO, OPB_IS_U_IMM, 'h0, 'h0, 'h0, 'h1234_5037, 0, 'h1234_5000);
    add_alu(ALU_ADD, OPA_IS_RS1, OPB_IS_S_IMM, 'h100, 'h0, 'h0, 'hfe00_0c23, 0, 'hf8);
    add_alu(ALU_ADD, OPA_IS_NPC, OPB_IS_RS2, 'h0, 'h0, 'h2000, 'h0, 0, 'h2004);
    // broadcaster stalls for 3 cycles
    add_alu(ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, 'haaaa_5555, 'hffff_0000, 'h0, 'h0, 3, 'h5555_5555);
    // mul: func, rs1, rs2, flush, result
    add_mul(ALU_MUL, 'hffff_fffd, 'h7, 0, 'hffff_ffeb);
    add_mul(ALU_MULH, 'hffff_fffd, 'h7, 0, 'hffff_ffff);
    add_mul(ALU_MULHU, 'hffff_fffd, 'h7, 0, 'h6);
    add_mul(ALU_MULHSU, 'hffff_fffd, 'h7, 0, 'hffff_ffff);
    add_mul(ALU_MULHSU, 'h7, 'hffff_fffd, 0, 'h6);
    add_mul(ALU_MULH, 'h8000_0000, 'h8000_0000, 0, 'h4000_0000);
    add_mul(ALU_MUL, 'h3, 'h4, 1, 'hc);
    // br: kind, opa, opb, rs1, rs2, inst, taken, target, link value
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h9, 'h9, 'h0000_0863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h9, 'h8, 'h0000_0863, 0, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h9, 'h8, 'h0000_1863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h9, 'h9, 'h0000_1863, 0, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'hffff_ffff, 'h1, 'h0000_4863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h1, 'hffff_ffff, 'h0000_4863, 0, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h1, 'hffff_ffff, 'h0000_5863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'hffff_ffff, 'h1, 'h0000_5863, 0, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h1, 'hffff_ffff, 'h0000_6863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'hffff_ffff, 'h1, 'h0000_6863, 0, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'hffff_ffff, 'h1, 'h0000_7863, 1, 'h410, 'h0);
    add_br(BR_COND, OPA_IS_PC, OPB_IS_B_IMM, 'h1, 'hffff_ffff, 'h0000_7863, 0, 'h410, 'h0);
    // jal +8, jalr rs1+16
    add_br(BR_UNCOND, OPA_IS_PC, OPB_IS_J_IMM, 'h0, 'h0, 'h0080_006f, 1, 'h408, 'h404);
    add_br(BR_UNCOND, OPA_IS_RS1, OPB_IS_I_IMM, 'h3000, 'h0, 'h0100_0067, 1, 'h3010, 'h404);
endtask

`endif

// File: test/tb_fu_top.sv
/*
 * Testbench for fu_top. Runs the vector table, then a few random ALU ops.
 * One lane is exercised at a time; issue fields are shared by all lanes.
 */
`timescale 1ns/1ps
`include "fu_macros.svh"

module tb_fu_top;
    import isa_pkg::*;
    import fu_pkg::*;

    typedef struct {
        int                  lane;
        alu_func_e           func;
        opa_sel_e            opa;
        opb_sel_e            opb;
        br_kind_e            kind;
        logic [`FU_XLEN-1:0] rs1, rs2, pc, inst;
        int                  dly;
        bit                  fl;
        logic [`FU_XLEN-1:0] res;
        bit                  taken;
        logic [`FU_XLEN-1:0] target;
    } vec_t;

    logic clk_i = 1'b0;
    logic rst_i, flush_i, ack;
    logic alu_valid, mul_valid, br_valid;
    logic alu_ready, mul_ready, br_ready;
    logic alu_res_valid, mul_res_valid, br_res_valid;
    logic [`FU_XLEN-1:0] alu_res, mul_res, br_res, br_target;
    tag_t alu_res_tag, mul_res_tag, br_res_tag, tag_in;
    logic br_taken, br_link;
    alu_func_e func;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    br_kind_e kind;
    logic [`FU_XLEN-1:0] rs1, rs2, pc, inst;

    vec_t        vecs[$];
    int          errors = 0;
    int          cur_lane = 0;
    bit          table_ready = 1'b0;
    logic [31:0] lcg_state = 32'd86;

    // lane currently under test
    logic                cur_valid, cur_ready;
    logic [`FU_XLEN-1:0] cur_res;
    tag_t                cur_tag;
    assign cur_valid = (cur_lane == 0) ? alu_res_valid
                     : (cur_lane == 1) ? mul_res_valid : br_res_valid;
    assign cur_ready = (cur_lane == 0) ? alu_ready
                     : (cur_lane == 1) ? mul_ready : br_ready;
    assign cur_res   = (cur_lane == 0) ? alu_res
                     : (cur_lane == 1) ? mul_res : br_res;
    assign cur_tag   = (cur_lane == 0) ? alu_res_tag
                     : (cur_lane == 1) ? mul_res_tag : br_res_tag;

    always #50 clk_i = ~clk_i;

    fu_top i_fu_top (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (flush_i),
        .alu_valid_i (alu_valid), .alu_ready_o (alu_ready), .alu_func_i (func),
        .alu_opa_sel_i (opa_sel), .alu_opb_sel_i (opb_sel), .alu_rs1_i (rs1), .alu_rs2_i (rs2),
        .alu_pc_i (pc), .alu_inst_i (inst), .alu_tag_i (tag_in),
        .alu_res_valid_o (alu_res_valid), .alu_res_o (alu_res), .alu_res_tag_o (alu_res_tag),
        .alu_ack_i (ack),
        .mul_valid_i (mul_valid), .mul_ready_o (mul_ready), .mul_func_i (func),
        .mul_opa_sel_i (opa_sel), .mul_opb_sel_i (opb_sel), .mul_rs1_i (rs1), .mul_rs2_i (rs2),
        .mul_pc_i (pc), .mul_inst_i (inst), .mul_tag_i (tag_in),
        .mul_res_valid_o (mul_res_valid), .mul_res_o (mul_res), .mul_res_tag_o (mul_res_tag),
        .mul_ack_i (ack),
        .br_valid_i (br_valid), .br_ready_o (br_ready), .br_func_i (func),
        .br_opa_sel_i (opa_sel), .br_opb_sel_i (opb_sel), .br_rs1_i (rs1), .br_rs2_i (rs2),
        .br_pc_i (pc), .br_inst_i (inst), .br_tag_i (tag_in), .br_kind_i (kind),
        .br_res_valid_o (br_res_valid), .br_res_o (br_res), .br_res_tag_o (br_res_tag),
        .br_ack_i (ack), .br_taken_o (br_taken), .br_target_o (br_target), .br_link_o (br_link)
    );

    ////////////////////
    // table helpers
    ////////////////////

    function automatic vec_t make_vec(input int lane, input alu_func_e f, input opa_sel_e a,
                                      input opb_sel_e b, input br_kind_e k,
                                      input logic [31:0] r1, r2, p, ins);
        vec_t v;
        v.lane = lane;
        v.func = f;
        v.opa = a;
        v.opb = b;
        v.kind = k;
        v.rs1 = r1;
        v.rs2 = r2;
        v.pc = p;
        v.inst = ins;
        v.dly = 0;
        v.fl = 1'b0;
        v.res = '0;
        v.taken = 1'b0;
        v.target = '0;
        return v;
    endfunction

    task automatic add_alu(input alu_func_e f, input opa_sel_e a, input opb_sel_e b,
                           input logic [31:0] r1, r2, p, ins, input int dly,
                           input logic [31:0] res);
        vec_t v;
        v = make_vec(0, f, a, b, BR_COND, r1, r2, p, ins);
        v.dly = dly;
        v.res = res;
        vecs.push_back(v);
    endtask

    task automatic add_mul(input alu_func_e f, input logic [31:0] r1, r2, input bit fl,
                           input logic [31:0] res);
        vec_t v;
        v = make_vec(1, f, OPA_IS_RS1, OPB_IS_RS2, BR_COND, r1, r2, '0, '0);
        v.fl = fl;
        v.res = res;
        vecs.push_back(v);
    endtask

    task automatic add_br(input br_kind_e k, input opa_sel_e a, input opb_sel_e b,
                          input logic [31:0] r1, r2, ins, input bit tk,
                          input logic [31:0] tgt, res);
        vec_t v;
        v = make_vec(2, ALU_ADD, a, b, k, r1, r2, 32'h400, ins);
        v.taken = tk;
        v.target = tgt;
        v.res = res;
        vecs.push_back(v);
    endtask

    `include "fu_vectors.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random operands, expected value from the RV32 definition of the op
    task automatic add_random(input int n);
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < n; k++) begin
            a = lcg_next();
            b = lcg_next();
            case (k % 3)
                0: add_alu(ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, '0, 0, a + b);
                1: add_alu(ALU_SUB, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, '0, 0, a - b);
                default: add_alu(ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, '0, 0, a ^ b);
            endcase
        end
    endtask

    ////////////////////
    // checking
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // single-bit flags and handshakes
    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic int lane_latency(input int lane);
        return (lane == 0) ? `FU_ALU_LAT : (lane == 1) ? `FU_MULT_LAT : `FU_BR_LAT;
    endfunction

    task automatic check_outputs(input vec_t v, input tag_t t);
        check_bit("res_valid_o", cur_valid, 1'b1);
        check_value("res_o", cur_res, v.res);
        check_value("res_tag_o", 32'(cur_tag), 32'(t));
        // ack is low, so the lane must stay closed
        check_bit("ready_o", cur_ready, 1'b0);
        if (v.lane == 2) begin
            check_bit("br_taken_o", br_taken, v.taken);
            check_value("br_target_o", br_target, v.target);
            check_bit("br_link_o", br_link, v.kind == BR_UNCOND);
        end
    endtask

    task automatic apply_vec(input vec_t v, input tag_t t);
        int cycles;
        cur_lane = v.lane;
        @(posedge clk_i);
        func <= v.func;
        opa_sel <= v.opa;
        opb_sel <= v.opb;
        kind <= v.kind;
        rs1 <= v.rs1;
        rs2 <= v.rs2;
        pc <= v.pc;
        inst <= v.inst;
        tag_in <= t;
        alu_valid <= (v.lane == 0);
        mul_valid <= (v.lane == 1);
        br_valid <= (v.lane == 2);
        @(negedge clk_i);
        check_bit("ready_o before issue", cur_ready, 1'b1);
        // accepting edge
        @(posedge clk_i);
        alu_valid <= 1'b0;
        mul_valid <= 1'b0;
        br_valid <= 1'b0;
        if (v.fl) begin
            @(posedge clk_i);
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
            @(negedge clk_i);
            check_bit("ready_o after flush", cur_ready, 1'b1);
            repeat (4) begin
                @(negedge clk_i);
                check_bit("res_valid_o after flush", cur_valid, 1'b0);
            end
        end else begin
            cycles = 0;
            do begin
                @(negedge clk_i);
                cycles++;
            end while (!cur_valid && cycles < 20);
            check_value("res_valid_o latency", cycles, lane_latency(v.lane));
            check_outputs(v, t);
            repeat (v.dly) begin
                @(negedge clk_i);
                check_outputs(v, t);
            end
            @(posedge clk_i);
            ack <= 1'b1;
            @(negedge clk_i);
            check_bit("ready_o on ack", cur_ready, 1'b1);
            @(posedge clk_i);
            ack <= 1'b0;
            @(negedge clk_i);
            check_bit("res_valid_o after ack", cur_valid, 1'b0);
        end
    endtask

    ////////////////////
    // main and watchdog
    ////////////////////

    initial begin
        rst_i = 1'b1;
        flush_i = 1'b0;
        ack = 1'b0;
        alu_valid = 1'b0;
        mul_valid = 1'b0;
        br_valid = 1'b0;
        func = ALU_ADD;
        opa_sel = OPA_IS_RS1;
        opb_sel = OPB_IS_RS2;
        kind = BR_COND;
        rs1 = '0;
        rs2 = '0;
        pc = '0;
        inst = '0;
        tag_in = '0;
        load_table();
        add_random(6);
        table_ready = 1'b1;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_bit("alu_res_valid_o after reset", alu_res_valid, 1'b0);
        check_bit("mul_res_valid_o after reset", mul_res_valid, 1'b0);
        check_bit("br_res_valid_o after reset", br_res_valid, 1'b0);
        check_bit("alu_ready_o after reset", alu_ready, 1'b1);
        check_bit("mul_ready_o after reset", mul_ready, 1'b1);
        check_bit("br_ready_o after reset", br_ready, 1'b1);
        foreach (vecs[i]) begin
            apply_vec(vecs[i], tag_t'(i));
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // budget of 20 cycles per entry plus margin for reset
    initial begin
        wait (table_ready);
        repeat (vecs.size() * 20 + 50) @(posedge clk_i);
        $display("watchdog expired before all vectors were applied");
        $display("errors: %0d", errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+src
+incdir+test
src/isa_pkg.sv
src/fu_pkg.sv
src/operand_select.sv
src/fu_issue_ctrl.sv
src/alu_core.sv
src/mult_core.sv
src/branch_resolve.sv
src/fu_top.sv
test/tb_fu_top.sv

// File: Makefile
TOP := tb_fu_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
